/* bench/core_vectors.txt */
// header: program word count, store count, halt pc
// then program words from address 0, then store pairs as address and data
00000032 0000000F 000000C4
10000513 12300093 FFB00113 002081B3
00352023 40208233 00452223 001122B3
00113333 00552423 00652623 40415393
00415413 0083C4B3 00952823 123455B7
6785E593 00B52A23 00001617 00C52C23
0085F6B3 00469693 00D52E23 00208463
02152023 00209463 02052223 00114463
02052223 00116463 05500713 02E52223
00C007EF 02052423 02052423 02F52423
01C78867 02052623 02052623 02052623
03052623 0020D463 02052623 0020F463
02152823 02952A23 03452903 00190913
03252C23 00100073
// alu and upper immediate results
00000100 0000011E
00000104 00000128
00000108 00000001
0000010C 00000000
00000110 F0000000
00000114 12345678
00000118 00001048
0000011C 23456780
// branch markers and link values
00000120 00000123
00000124 00000055
00000128 00000084
0000012C 00000094
00000130 00000123
// store, load back and store again
00000134 F0000000
00000138 F0000001

/* tb.f */
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/load_store_unit.sv
hdl/mem_arbiter.sv
hdl/core_top.sv
bench/clock_gen.sv
bench/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

SRCS := $(filter-out +%,$(shell cat tb.f))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): tb.f $(SRCS)
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f

run: $(BIN) bench/core_vectors.txt
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

check:
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/core_tb.sv */
`timescale 1ns/10ps

module core_tb;
  import rv_pkg::*;

  localparam addr_t RESET_PC      = 32'h0000_0000;
  localparam int    MEM_WORDS     = 1024;
  localparam int    VEC_WORDS     = 256;
  localparam int    MAX_STORES    = 64;
  localparam int    START_TIMEOUT = 50;
  localparam int    HALT_TIMEOUT  = 20000;
  // store groups of the program in the vectors file.
  localparam int    ALU_END       = 8;
  localparam int    BRANCH_END    = 13;

  logic  clock;
  logic  reset;
  logic  restart = 1'b0;
  logic  mem_ready = 1'b0;
  word_t mem_rdata;
  logic  mem_valid;
  logic  mem_write;
  addr_t mem_addr;
  word_t mem_wdata;
  logic  halted;
  addr_t halt_pc;

  word_t vec [0:VEC_WORDS-1];
  word_t mem [0:MEM_WORDS-1];
  int    prog_words;
  int    store_count;
  addr_t exp_halt_pc;
  bit    random_stall = 1'b0;
  int    tests_run;
  int    tests_failed;

  int    store_idx;
  bit    store_bad [0:MAX_STORES-1];
  int    extra_stores;
  int    late_writes;
  int    unstable;
  bit    first_seen;
  bit    first_bad;
  bit    wait_prev;
  logic  prev_write;
  addr_t prev_addr;
  word_t prev_wdata;

  clock_gen #(.PERIOD(100), .RESET_CYCLES(3)) clock_gen_i (
    .restart, .clock, .reset
  );

  core_top #(.RESET_PC(RESET_PC)) core_top_i (
    .clock, .reset, .mem_ready, .mem_rdata, .mem_valid, .mem_write, .mem_addr,
    .mem_wdata, .halted, .halt_pc
  );

  assign mem_rdata = mem[mem_addr[11:2]];

  // words outside the program get a pattern built from their full address.
  function automatic word_t image_word(int i);
    if (i < prog_words) begin
      return vec[3 + i];
    end
    return (addr_t'(i) << 2) ^ 32'hA5A5_A5A5;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act,
                            output bit ok);
    ok = (exp === act);
    if (!ok) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act,
                            output bit ok);
    ok = (exp === act);
    if (!ok) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act,
                           output bit ok);
    ok = (exp === act);
    if (!ok) begin
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // the memory is always ready in the first run and randomly stalls in the rerun.
  initial begin
    void'($urandom(32'h71b7_b1a9));
    forever begin
      @(negedge clock);
      mem_ready <= random_stall ? ($urandom_range(3) != 0) : 1'b1;
    end
  end

  // memory model and bus monitor.
  always @(posedge clock) begin : bus_model
    bit ok_v;
    bit ok_a;
    bit ok_d;
    bit ok_w;
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= image_word(i);
      end
      for (int i = 0; i < MAX_STORES; i++) begin
        store_bad[i] <= 1'b0;
      end
      store_idx    <= 0;
      extra_stores <= 0;
      late_writes  <= 0;
      unstable     <= 0;
      first_seen   <= 1'b0;
      first_bad    <= 1'b0;
      wait_prev    <= 1'b0;
    end else begin
      if (wait_prev) begin
        check_bit("mem_valid", 1'b1, mem_valid, ok_v);
        check_addr("mem_addr", prev_addr, mem_addr, ok_a);
        check_word("mem_wdata", prev_wdata, mem_wdata, ok_d);
        check_bit("mem_write", prev_write, mem_write, ok_w);
        if (!(ok_v && ok_a && ok_d && ok_w)) begin
          unstable <= unstable + 1;
        end
      end
      wait_prev  <= mem_valid && !mem_ready;
      prev_addr  <= mem_addr;
      prev_wdata <= mem_wdata;
      prev_write <= mem_write;
      if (mem_valid && mem_ready) begin
        if (!first_seen) begin
          first_seen <= 1'b1;
          check_addr("mem_addr", RESET_PC, mem_addr, ok_a);
          check_bit("mem_write", 1'b0, mem_write, ok_w);
          if (!(ok_a && ok_w)) begin
            first_bad <= 1'b1;
          end
        end
        if (mem_write) begin
          mem[mem_addr[11:2]] <= mem_wdata;
          if (halted) begin
            $display("bus write to %h at %0t after the core halted", mem_addr, $time);
            late_writes <= late_writes + 1;
          end
          if (store_idx >= store_count) begin
            $display("unexpected extra store to %h at %0t", mem_addr, $time);
            extra_stores <= extra_stores + 1;
          end else begin
            check_addr("mem_addr", vec[3 + prog_words + 2 * store_idx], mem_addr, ok_a);
            check_word("mem_wdata", vec[4 + prog_words + 2 * store_idx], mem_wdata, ok_d);
            if (!(ok_a && ok_d)) begin
              store_bad[store_idx] <= 1'b1;
            end
          end
          store_idx <= store_idx + 1;
        end
      end
    end
  end

  function automatic bit stores_ok(int lo, int hi);
    if (store_idx < hi) begin
      return 1'b0;
    end
    for (int i = lo; i < hi; i++) begin
      if (store_bad[i]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic report(input string name, input bit passed);
    tests_run++;
    if (!passed) begin
      tests_failed++;
    end
    $display("%-28s %s", name, passed ? "pass" : "fail");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic wait_for_reset_cycle(output bit idle_ok);
    int cycles;
    bit ok_v;
    bit ok_h;
    idle_ok = 1'b1;
    cycles  = 0;
    while (reset !== 1'b1) begin
      @(negedge clock);
      cycles++;
      if (cycles > START_TIMEOUT) abort_run("reset never rose");
    end
    cycles = 0;
    while (reset !== 1'b0) begin
      @(negedge clock);
      cycles++;
      if (cycles > START_TIMEOUT) abort_run("reset was never released");
      // a rising edge under reset has passed, so the bus and halt must be idle.
      if (reset === 1'b1) begin
        check_bit("mem_valid", 1'b0, mem_valid, ok_v);
        check_bit("halted", 1'b0, halted, ok_h);
        idle_ok = idle_ok && ok_v && ok_h;
      end
    end
  endtask

  task automatic run_phase(input bit stalled);
    int  cycles;
    bit  idle_ok;
    bit  ok_pc;
    bit  count_ok;
    wait_for_reset_cycle(idle_ok);
    cycles = 0;
    while (!first_seen) begin
      @(negedge clock);
      cycles++;
      if (cycles > START_TIMEOUT) abort_run("no bus read after reset");
    end
    if (!stalled) begin
      report("reset and first fetch", idle_ok && !first_bad);
    end
    cycles = 0;
    while (halted !== 1'b1) begin
      @(negedge clock);
      cycles++;
      if (cycles > HALT_TIMEOUT) abort_run("core did not halt in time");
    end
    // a short window after the halt in which no write may appear.
    repeat (20) @(negedge clock);
    check_addr("halt_pc", exp_halt_pc, halt_pc, ok_pc);
    count_ok = (store_idx == store_count) && (extra_stores == 0);
    if (!count_ok) begin
      $display("saw %0d stores where %0d were expected", store_idx, store_count);
    end
    if (!stalled) begin
      report("alu and upper immediates", stores_ok(0, ALU_END));
      report("branches and jumps", stores_ok(ALU_END, BRANCH_END) && count_ok);
      report("load after store", stores_ok(BRANCH_END, store_count));
      report("halt", ok_pc && late_writes == 0);
    end else begin
      report("rerun store sequence", stores_ok(0, store_count) && count_ok);
      report("bus hold under stall", unstable == 0);
      report("halt under stall", ok_pc && late_writes == 0);
    end
  endtask

  initial begin
    tests_run    = 0;
    tests_failed = 0;
    $readmemh("bench/core_vectors.txt", vec);
    prog_words  = vec[0];
    store_count = vec[1];
    exp_halt_pc = vec[2];
    run_phase(1'b0);
    @(negedge clock);
    random_stall = 1'b1;
    restart      = 1'b1;
    @(negedge clock);
    restart = 1'b0;
    run_phase(1'b1);
    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 3
) (
  input  logic restart,
  output logic clock,
  output logic reset
);

  initial clock = 1'b0;
  always #(PERIOD / 2) clock = ~clock;

  // reset is released on a falling edge and raised again whenever restart rises.
  initial begin
    reset = 1'b1;
    forever begin
      repeat (RESET_CYCLES) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      @(posedge restart);
      @(negedge clock);
      reset = 1'b1;
    end
  end

endmodule

/* hdl/core_top.sv */
`timescale 1ns/10ps

module core_top #(
  parameter rv_pkg::addr_t RESET_PC = 32'h0000_0000
) (
  input  logic          clock,
  input  logic          reset,
  input  logic          mem_ready,
  input  rv_pkg::word_t mem_rdata,
  output logic          mem_valid,
  output logic          mem_write,
  output rv_pkg::addr_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  output logic          halted,
  output rv_pkg::addr_t halt_pc
);
  import rv_pkg::*;

  logic     if_valid, if_ready;
  word_t    if_instr;
  addr_t    if_pc;
  reg_idx_t rs1_idx, rs2_idx;
  word_t    rs1_data, rs2_data;
  logic     id_valid, exec_idle;
  addr_t    id_pc;
  word_t    id_imm, id_src1, id_src2;
  alu_op_t  id_alu_op;
  logic     id_use_imm, id_mem_write, id_halt;
  npc_sel_t id_npc_sel;
  br_cond_t id_br_cond;
  wb_sel_t  id_wb_sel;
  reg_idx_t id_rd;
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;
  logic     redirect;
  addr_t    redirect_pc;
  logic     ls_valid, ls_ready, ls_write, ls_done;
  addr_t    ls_addr;
  word_t    ls_wdata, ls_rdata;
  logic     f_valid, f_ready;
  addr_t    f_addr;
  word_t    f_rdata;
  logic     l_valid, l_ready, l_write;
  addr_t    l_addr;
  word_t    l_wdata, l_rdata;

  fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_i (
    .clock, .reset, .redirect, .redirect_pc, .halt(halted),
    .req_ready(f_ready), .req_rdata(f_rdata), .if_ready,
    .req_valid(f_valid), .req_addr(f_addr), .if_valid, .if_instr, .if_pc
  );

  decode_unit decode_unit_i (
    .clock, .reset, .if_valid, .if_instr, .if_pc,
    .exec_idle, .redirect, .rs1_data, .rs2_data,
    .if_ready, .rs1_idx, .rs2_idx, .id_valid, .id_pc, .id_imm, .id_src1, .id_src2,
    .id_alu_op, .id_use_imm, .id_npc_sel, .id_br_cond, .id_wb_sel, .id_rd,
    .id_mem_write, .id_halt
  );

  register_file register_file_i (
    .clock, .rs1_idx, .rs2_idx, .wr_en, .wr_idx, .wr_data, .rs1_data, .rs2_data
  );

  execute_unit execute_unit_i (
    .clock, .reset, .id_valid, .id_pc, .id_imm, .id_src1, .id_src2, .id_alu_op,
    .id_use_imm, .id_npc_sel, .id_br_cond, .id_wb_sel, .id_rd, .id_mem_write, .id_halt,
    .ls_ready, .ls_done, .ls_rdata, .id_ready(), .exec_idle, .wr_en, .wr_idx, .wr_data,
    .redirect, .redirect_pc, .ls_valid, .ls_write, .ls_addr, .ls_wdata, .halted, .halt_pc
  );

  load_store_unit load_store_unit_i (
    .clock, .reset, .ls_valid, .ls_write, .ls_addr, .ls_wdata,
    .req_ready(l_ready), .req_rdata(l_rdata), .ls_ready, .ls_done, .ls_rdata,
    .req_valid(l_valid), .req_write(l_write), .req_addr(l_addr), .req_wdata(l_wdata)
  );

  mem_arbiter mem_arbiter_i (
    .clock, .reset, .f_valid, .f_addr, .l_valid, .l_write, .l_addr, .l_wdata,
    .mem_ready, .mem_rdata, .f_ready, .f_rdata, .l_ready, .l_rdata,
    .mem_valid, .mem_write, .mem_addr, .mem_wdata
  );

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
  input  logic          clock,
  input  logic          reset,
  input  logic          f_valid,
  input  rv_pkg::addr_t f_addr,
  input  logic          l_valid,
  input  logic          l_write,
  input  rv_pkg::addr_t l_addr,
  input  rv_pkg::word_t l_wdata,
  input  logic          mem_ready,
  input  rv_pkg::word_t mem_rdata,
  output logic          f_ready,
  output rv_pkg::word_t f_rdata,
  output logic          l_ready,
  output rv_pkg::word_t l_rdata,
  output logic          mem_valid,
  output logic          mem_write,
  output rv_pkg::addr_t mem_addr,
  output rv_pkg::word_t mem_wdata
);

  logic last_l;
  logic busy;
  logic grant_q;
  logic sel_l;

  // a stalled transfer keeps its grant, otherwise the port that lost last wins a tie.
  assign sel_l = busy ? grant_q : (l_valid && (!f_valid || !last_l));

  assign mem_valid = sel_l ? l_valid : f_valid;
  assign mem_write = sel_l && l_write;
  assign mem_addr  = sel_l ? l_addr : f_addr;
  assign mem_wdata = sel_l ? l_wdata : 32'd0;

  assign f_ready = !sel_l && mem_ready;
  assign l_ready = sel_l && mem_ready;
  assign f_rdata = mem_rdata;
  assign l_rdata = mem_rdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      last_l  <= 1'b0;
      busy    <= 1'b0;
      grant_q <= 1'b0;
    end else begin
      busy    <= mem_valid && !mem_ready;
      grant_q <= sel_l;
      if (mem_valid && mem_ready) begin
        last_l <= sel_l;
      end
    end
  end

endmodule

/* hdl/load_store_unit.sv */
`timescale 1ns/10ps

module load_store_unit (
  input  logic          clock,
  input  logic          reset,
  input  logic          ls_valid,
  input  logic          ls_write,
  input  rv_pkg::addr_t ls_addr,
  input  rv_pkg::word_t ls_wdata,
  input  logic          req_ready,
  input  rv_pkg::word_t req_rdata,
  output logic          ls_ready,
  output logic          ls_done,
  output rv_pkg::word_t ls_rdata,
  output logic          req_valid,
  output logic          req_write,
  output rv_pkg::addr_t req_addr,
  output rv_pkg::word_t req_wdata
);
  import rv_pkg::*;

  lsu_state_e state;

  assign ls_ready  = state == LS_IDLE;
  assign req_valid = state == LS_BUS;

  // the request is captured once so the bus sees a stable payload.
  always_ff @(posedge clock) begin
    if (state == LS_IDLE && ls_valid) begin
      req_write <= ls_write;
      req_addr  <= ls_addr;
      req_wdata <= ls_wdata;
    end
    if (req_valid && req_ready) begin
      ls_rdata <= req_rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= LS_IDLE;
      ls_done <= 1'b0;
    end else begin
      ls_done <= req_valid && req_ready;
      case (state)
        LS_IDLE: begin
          if (ls_valid) begin
            state <= LS_BUS;
          end
        end
        default: begin
          if (req_ready) begin
            state <= LS_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/10ps

module execute_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             id_valid,
  input  rv_pkg::addr_t    id_pc,
  input  rv_pkg::word_t    id_imm,
  input  rv_pkg::word_t    id_src1,
  input  rv_pkg::word_t    id_src2,
  input  rv_pkg::alu_op_t  id_alu_op,
  input  logic             id_use_imm,
  input  rv_pkg::npc_sel_t id_npc_sel,
  input  rv_pkg::br_cond_t id_br_cond,
  input  rv_pkg::wb_sel_t  id_wb_sel,
  input  rv_pkg::reg_idx_t id_rd,
  input  logic             id_mem_write,
  input  logic             id_halt,
  input  logic             ls_ready,
  input  logic             ls_done,
  input  rv_pkg::word_t    ls_rdata,
  output logic             id_ready,
  output logic             exec_idle,
  output logic             wr_en,
  output rv_pkg::reg_idx_t wr_idx,
  output rv_pkg::word_t    wr_data,
  output logic             redirect,
  output rv_pkg::addr_t    redirect_pc,
  output logic             ls_valid,
  output logic             ls_write,
  output rv_pkg::addr_t    ls_addr,
  output rv_pkg::word_t    ls_wdata,
  output logic             halted,
  output rv_pkg::addr_t    halt_pc
);
  import rv_pkg::*;

  exec_state_e state;
  addr_t       pc_q;
  word_t       imm_q;
  word_t       src1_q;
  word_t       src2_q;
  alu_op_t     alu_op_q;
  logic        use_imm_q;
  npc_sel_t    npc_sel_q;
  br_cond_t    br_cond_q;
  wb_sel_t     wb_sel_q;
  reg_idx_t    id_rd_q;
  logic        mem_write_q;
  logic        halt_q;
  logic        ls_sent;
  word_t       alu_res;
  addr_t       snpc;
  addr_t       jmp_pc;
  logic        taken;
  logic        is_mem;

  function automatic word_t alu(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_SUB:    return a - b;
      ALU_AND:    return a & b;
      ALU_OR:     return a | b;
      ALU_XOR:    return a ^ b;
      ALU_SLT:    return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   return {31'b0, a < b};
      ALU_SLL:    return a << b[4:0];
      ALU_SRL:    return a >> b[4:0];
      ALU_SRA:    return word_t'($signed(a) >>> b[4:0]);
      ALU_PASS_B: return b;
      default:    return a + b;
    endcase
  endfunction

  function automatic logic br_taken(br_cond_t cond, word_t a, word_t b);
    case (cond)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  assign alu_res = alu(alu_op_q, src1_q, use_imm_q ? imm_q : src2_q);
  assign snpc    = pc_q + 32'd4;
  assign jmp_pc  = pc_q + imm_q;
  assign is_mem  = mem_write_q || wb_sel_q == WB_MEM;

  always_comb begin
    case (npc_sel_q)
      NPC_JAL:    taken = 1'b1;
      NPC_JALR:   taken = 1'b1;
      NPC_BRANCH: taken = br_taken(br_cond_q, src1_q, src2_q);
      default:    taken = 1'b0;
    endcase
  end

  assign redirect    = state == EX_RUN && taken;
  assign redirect_pc = (npc_sel_q == NPC_JALR) ? (alu_res & ~32'd1) : jmp_pc;

  assign id_ready  = state == EX_IDLE;
  assign exec_idle = state == EX_IDLE;
  assign halted    = state == EX_HALT;
  assign halt_pc   = pc_q;

  // ALU and link results retire in EX_RUN, load data when the unit reports done.
  assign wr_en   = (state == EX_RUN && (wb_sel_q == WB_ALU || wb_sel_q == WB_SNPC)) ||
                   (state == EX_MEM_WAIT && ls_done && wb_sel_q == WB_MEM);
  assign wr_idx  = id_rd_q;
  assign wr_data = (wb_sel_q == WB_SNPC) ? snpc : (wb_sel_q == WB_MEM) ? ls_rdata : alu_res;

  assign ls_valid = state == EX_MEM_WAIT && !ls_sent;
  assign ls_write = mem_write_q;
  assign ls_addr  = alu_res;
  assign ls_wdata = src2_q;

  always_ff @(posedge clock) begin
    if (state == EX_IDLE && id_valid) begin
      pc_q        <= id_pc;
      imm_q       <= id_imm;
      src1_q      <= id_src1;
      src2_q      <= id_src2;
      alu_op_q    <= id_alu_op;
      use_imm_q   <= id_use_imm;
      npc_sel_q   <= id_npc_sel;
      br_cond_q   <= id_br_cond;
      wb_sel_q    <= id_wb_sel;
      id_rd_q     <= id_rd;
      mem_write_q <= id_mem_write;
      halt_q      <= id_halt;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= EX_IDLE;
      ls_sent <= 1'b0;
    end else begin
      case (state)
        EX_IDLE: begin
          if (id_valid) begin
            state <= EX_RUN;
          end
        end
        EX_RUN: begin
          if (halt_q) begin
            state <= EX_HALT;
          end else if (is_mem) begin
            state <= EX_MEM_WAIT;
          end else begin
            state <= EX_IDLE;
          end
        end
        EX_MEM_WAIT: begin
          if (ls_valid && ls_ready) begin
            ls_sent <= 1'b1;
          end
          if (ls_done) begin
            ls_sent <= 1'b0;
            state   <= EX_IDLE;
          end
        end
        default: state <= EX_HALT;
      endcase
    end
  end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/10ps

module register_file (
  input  logic             clock,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  logic             wr_en,
  input  rv_pkg::reg_idx_t wr_idx,
  input  rv_pkg::word_t    wr_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  // x0 has no storage.
  word_t regs [1:31];

  always_ff @(posedge clock) begin
    if (wr_en && wr_idx != 5'd0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rs1_data = (rs1_idx == 5'd0) ? 32'd0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == 5'd0) ? 32'd0 : regs[rs2_idx];

endmodule

/* hdl/decode_unit.sv */
`timescale 1ns/10ps

module decode_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             if_valid,
  input  rv_pkg::word_t    if_instr,
  input  rv_pkg::addr_t    if_pc,
  input  logic             exec_idle,
  input  logic             redirect,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output logic             if_ready,
  output rv_pkg::reg_idx_t rs1_idx,
  output rv_pkg::reg_idx_t rs2_idx,
  output logic             id_valid,
  output rv_pkg::addr_t    id_pc,
  output rv_pkg::word_t    id_imm,
  output rv_pkg::word_t    id_src1,
  output rv_pkg::word_t    id_src2,
  output rv_pkg::alu_op_t  id_alu_op,
  output logic             id_use_imm,
  output rv_pkg::npc_sel_t id_npc_sel,
  output rv_pkg::br_cond_t id_br_cond,
  output rv_pkg::wb_sel_t  id_wb_sel,
  output rv_pkg::reg_idx_t id_rd,
  output logic             id_mem_write,
  output logic             id_halt
);
  import rv_pkg::*;

  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam word_t      EBREAK    = 32'h0010_0073;

  logic       inst_valid;
  word_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  alu_op_t    arith_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  // execute is idle whenever an instruction is offered, so offering is issuing.
  assign id_valid = inst_valid && exec_idle;
  assign if_ready = !inst_valid || id_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_valid <= 1'b0;
    end else if (redirect) begin
      inst_valid <= 1'b0;
    end else if (if_valid && if_ready) begin
      inst_valid <= 1'b1;
      instr      <= if_instr;
      id_pc      <= if_pc;
    end else if (id_valid) begin
      inst_valid <= 1'b0;
    end
  end

  assign rs1_idx    = instr[19:15];
  assign rs2_idx    = instr[24:20];
  assign id_rd      = instr[11:7];
  assign id_br_cond = funct3;
  assign id_src1    = (opcode == OP_AUIPC) ? id_pc : rs1_data;
  assign id_src2    = rs2_data;

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = instr[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    id_imm       = {{20{instr[31]}}, instr[31:20]};
    id_alu_op    = ALU_ADD;
    id_use_imm   = 1'b1;
    id_npc_sel   = NPC_SEQ;
    id_wb_sel    = WB_NONE;
    id_mem_write = 1'b0;
    id_halt      = 1'b0;
    case (opcode)
      OP_REG: begin
        id_alu_op  = arith_op;
        id_use_imm = 1'b0;
        id_wb_sel  = WB_ALU;
      end
      OP_IMM: begin
        id_alu_op = arith_op;
        id_wb_sel = WB_ALU;
      end
      OP_LUI, OP_AUIPC: begin
        id_imm    = {instr[31:12], 12'b0};
        id_alu_op = (opcode == OP_LUI) ? ALU_PASS_B : ALU_ADD;
        id_wb_sel = WB_ALU;
      end
      OP_JAL: begin
        id_imm     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        id_npc_sel = NPC_JAL;
        id_wb_sel  = WB_SNPC;
      end
      OP_JALR: begin
        id_npc_sel = NPC_JALR;
        id_wb_sel  = WB_SNPC;
      end
      OP_BRANCH: begin
        id_imm     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        id_npc_sel = NPC_BRANCH;
      end
      OP_LOAD: id_wb_sel = WB_MEM;
      OP_STORE: begin
        id_imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        id_mem_write = 1'b1;
      end
      default: id_halt = (instr == EBREAK);
    endcase
  end

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit #(
  parameter rv_pkg::addr_t RESET_PC = 32'h0000_0000
) (
  input  logic          clock,
  input  logic          reset,
  input  logic          redirect,
  input  rv_pkg::addr_t redirect_pc,
  input  logic          halt,
  input  logic          req_ready,
  input  rv_pkg::word_t req_rdata,
  input  logic          if_ready,
  output logic          req_valid,
  output rv_pkg::addr_t req_addr,
  output logic          if_valid,
  output rv_pkg::word_t if_instr,
  output rv_pkg::addr_t if_pc
);
  import rv_pkg::*;

  addr_t pc;
  addr_t tgt_pc;
  logic  pend;
  logic  drop;

  // a request that has started is held until the bus takes it.
  assign req_valid = pend || (!reset && !halt && !redirect && (!if_valid || if_ready));
  assign req_addr  = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc       <= RESET_PC;
      pend     <= 1'b0;
      drop     <= 1'b0;
      if_valid <= 1'b0;
    end else begin
      pend <= req_valid && !req_ready;
      if (redirect) begin
        if_valid <= 1'b0;
        // the word still in flight belongs to the old path and is thrown away.
        if (req_valid && !req_ready) begin
          drop   <= 1'b1;
          tgt_pc <= redirect_pc;
        end else begin
          pc <= redirect_pc;
        end
      end else if (req_valid && req_ready) begin
        if (drop) begin
          drop <= 1'b0;
          pc   <= tgt_pc;
        end else begin
          if_valid <= 1'b1;
          if_instr <= req_rdata;
          if_pc    <= pc;
          pc       <= pc + 32'd4;
        end
      end else if (if_valid && if_ready) begin
        if_valid <= 1'b0;
      end
    end
  end

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  // ALU operation codes.
  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_AND    = 4'd2;
  localparam alu_op_t ALU_OR     = 4'd3;
  localparam alu_op_t ALU_XOR    = 4'd4;
  localparam alu_op_t ALU_SLT    = 4'd5;
  localparam alu_op_t ALU_SLTU   = 4'd6;
  localparam alu_op_t ALU_SLL    = 4'd7;
  localparam alu_op_t ALU_SRL    = 4'd8;
  localparam alu_op_t ALU_SRA    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;

  typedef logic [1:0] npc_sel_t;
  localparam npc_sel_t NPC_SEQ    = 2'd0;
  localparam npc_sel_t NPC_JAL    = 2'd1;
  localparam npc_sel_t NPC_JALR   = 2'd2;
  localparam npc_sel_t NPC_BRANCH = 2'd3;

  // the branch condition is the funct3 field of the branch instruction.
  typedef logic [2:0] br_cond_t;

  typedef logic [1:0] wb_sel_t;
  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_SNPC = 2'd1;
  localparam wb_sel_t WB_MEM  = 2'd2;
  localparam wb_sel_t WB_NONE = 2'd3;

  typedef enum logic [1:0] {EX_IDLE, EX_RUN, EX_MEM_WAIT, EX_HALT} exec_state_e;

  typedef enum logic {LS_IDLE, LS_BUS} lsu_state_e;

endpackage
